/* hdl/trace_pkg.sv */
`default_nettype none

package trace_pkg;

    // Data and address width of the core
    localparam int XLEN = 32;
    // Records held by the trace buffer
    localparam int TRACE_DEPTH = 16;
    // Buffer pointer and fill level widths
    localparam int PTR_W = $clog2(TRACE_DEPTH);
    localparam int LEVEL_W = PTR_W + 1;
    // Saturating dropped-record counter
    localparam int DROP_W = 16;
    localparam int REG_IDX_W = 5;
    // One mask bit per byte lane
    localparam int MASK_W = XLEN / 8;
    // Branch-to-self loop, taken as end of program
    localparam logic [XLEN-1:0] HALT_INSN = 32'h0000_0063;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [MASK_W-1:0] mask_t;

    // Per-stage hold levels from the core
    typedef struct packed {
        logic id;
        logic ex;
        logic mem;
        logic wb;
    } stall_t;

    // Word entering ID and its predicted successor
    typedef struct packed {
        word_t insn;
        word_t pc;
        word_t pc_next;
    } fetch_tap_t;

    // Forwarded operands and branch resolution in EX
    typedef struct packed {
        word_t rs1_rdata;
        word_t rs2_rdata;
        logic  redirect;
        word_t redirect_pc;
    } ex_tap_t;

    // Data port of the core
    typedef struct packed {
        word_t addr;
        word_t rdata;
        word_t wdata;
        logic  read;
        logic  write;
        mask_t byte_enable;
    } mem_tap_t;

    // Write-back view, valid low for a bubble
    typedef struct packed {
        logic     valid;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        word_t    rd_wdata;
    } wb_tap_t;

    // One record per retired instruction
    typedef struct packed {
        word_t    order;
        word_t    insn;
        word_t    pc_rdata;
        word_t    pc_wdata;
        reg_idx_t rs1_addr;
        reg_idx_t rs2_addr;
        word_t    rs1_rdata;
        word_t    rs2_rdata;
        reg_idx_t rd_addr;
        word_t    rd_wdata;
        word_t    mem_addr;
        mask_t    mem_rmask;
        mask_t    mem_wmask;
        word_t    mem_rdata;
        word_t    mem_wdata;
        logic     halt;
    } commit_rec_t;

    typedef enum logic [1:0] {
        IDLE,
        CAPTURE,
        HALTED
    } trace_state_t;

    // Reader-visible summary
    typedef struct packed {
        trace_state_t        state;
        logic [LEVEL_W-1:0]  level;
        logic [DROP_W-1:0]   dropped;
        word_t               retired;
    } trace_status_t;

endpackage

`default_nettype wire

/* hdl/shadow_pipe.sv */
`default_nettype none

module shadow_pipe (
    input  logic                   itf,
    input  trace_pkg::fetch_tap_t  fetch,
    input  trace_pkg::ex_tap_t     ex,
    input  trace_pkg::mem_tap_t    mem,
    input  trace_pkg::wb_tap_t     wb,
    input  trace_pkg::stall_t      stall,
    output logic                   commit,
    output trace_pkg::commit_rec_t rec
);
    import trace_pkg::*;

    // ID stage copies
    word_t insn_id;
    word_t pc_id;
    word_t pc_wdata_id;

    // EX stage copies
    word_t insn_ex;
    word_t pc_ex;
    word_t pc_wdata_ex;
    word_t rs1_rdata_ex;
    word_t rs2_rdata_ex;

    // MEM stage copies
    word_t insn_mem;
    word_t pc_mem;
    word_t pc_wdata_mem;
    word_t rs1_rdata_mem;
    word_t rs2_rdata_mem;

    // WB stage copies
    word_t insn_wb;
    word_t pc_wb;
    word_t pc_wdata_wb;
    word_t rs1_rdata_wb;
    word_t rs2_rdata_wb;

    // Data access latched alongside WB
    word_t mem_addr_wb;
    word_t mem_rdata_wb;
    word_t mem_wdata_wb;
    mask_t mem_rmask_wb;
    mask_t mem_wmask_wb;

    // Each stage holds exactly when the core's stage holds
    always_ff @(posedge itf) begin
        if (!stall.id) begin
            insn_id     <= fetch.insn;
            pc_id       <= fetch.pc;
            // Prediction already chosen by the core
            pc_wdata_id <= fetch.pc_next;
        end
    end

    always_ff @(posedge itf) begin
        if (!stall.ex) begin
            insn_ex      <= insn_id;
            pc_ex        <= pc_id;
            pc_wdata_ex  <= pc_wdata_id;
            // Operands after forwarding
            rs1_rdata_ex <= ex.rs1_rdata;
            rs2_rdata_ex <= ex.rs2_rdata;
        end
    end

    always_ff @(posedge itf) begin
        if (!stall.mem) begin
            insn_mem      <= insn_ex;
            pc_mem        <= pc_ex;
            // Resolved branch or jump overrides the prediction
            pc_wdata_mem  <= ex.redirect ? ex.redirect_pc : pc_wdata_ex;
            rs1_rdata_mem <= rs1_rdata_ex;
            rs2_rdata_mem <= rs2_rdata_ex;
        end
    end

    always_ff @(posedge itf) begin
        if (!stall.wb) begin
            insn_wb      <= insn_mem;
            pc_wb        <= pc_mem;
            pc_wdata_wb  <= pc_wdata_mem;
            rs1_rdata_wb <= rs1_rdata_mem;
            rs2_rdata_wb <= rs2_rdata_mem;
            // Memory access of the instruction leaving MEM
            mem_addr_wb  <= mem.addr;
            mem_rdata_wb <= mem.rdata;
            mem_wdata_wb <= mem.wdata;
            mem_rmask_wb <= mem.read ? '1 : '0;
            mem_wmask_wb <= mem.write ? mem.byte_enable : '0;
        end
    end

    // Real instruction leaving WB on this edge
    assign commit = wb.valid && !stall.wb;

    always_comb begin
        // Order is stamped by the counter downstream
        rec.order     = '0;
        rec.insn      = insn_wb;
        rec.pc_rdata  = pc_wb;
        rec.pc_wdata  = pc_wdata_wb;
        rec.rs1_addr  = wb.rs1;
        rec.rs2_addr  = wb.rs2;
        rec.rs1_rdata = rs1_rdata_wb;
        rec.rs2_rdata = rs2_rdata_wb;
        // x0 writes are reported as no write
        rec.rd_addr   = wb.rd;
        rec.rd_wdata  = (wb.rd == '0) ? '0 : wb.rd_wdata;
        rec.mem_addr  = mem_addr_wb;
        rec.mem_rmask = mem_rmask_wb;
        rec.mem_wmask = mem_wmask_wb;
        rec.mem_rdata = mem_rdata_wb;
        rec.mem_wdata = mem_wdata_wb;
        rec.halt      = (insn_wb == HALT_INSN);
    end

endmodule

`default_nettype wire

/* hdl/trace_ctrl.sv */
`default_nettype none

module trace_ctrl (
    input  logic                    itf,
    input  logic                    rst,
    input  logic                    start,
    input  logic                    clear,
    input  logic                    commit,
    input  logic                    halt,
    output trace_pkg::trace_state_t state,
    output logic                    capture,
    output logic                    flush
);
    import trace_pkg::*;

    trace_state_t state_next;

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                // Wait for the reader to arm
                if (start) begin
                    state_next = CAPTURE;
                end
            end
            CAPTURE: begin
                // Halt record still goes out on this edge
                if (commit && halt) begin
                    state_next = HALTED;
                end
            end
            HALTED: begin
                // Parked until clear
                state_next = HALTED;
            end
            default: begin
                state_next = IDLE;
            end
        endcase
        // Clear wins over everything else
        if (clear) begin
            state_next = IDLE;
        end
    end

    always_ff @(posedge itf) begin
        if (rst) begin
            state <= IDLE;
            // Empty buffer and counters once more after reset
            flush <= 1'b1;
        end else begin
            state <= state_next;
            // Buffer and counters empty on the edge after clear
            flush <= clear;
        end
    end

    // Only commits seen while capturing produce records
    assign capture = commit && (state == CAPTURE);

endmodule

`default_nettype wire

/* hdl/retire_counter.sv */
`default_nettype none

module retire_counter (
    input  logic                          itf,
    input  logic                          rst,
    input  logic                          flush,
    input  logic                          capture,
    input  logic                          full,
    output trace_pkg::word_t              order,
    output logic [trace_pkg::DROP_W-1:0]  dropped
);

    // Order of the next record, also the retired count
    always_ff @(posedge itf) begin
        if (rst || flush) begin
            order <= '0;
        end else if (capture) begin
            // Dropped records still consume an order number
            order <= order + 1'b1;
        end
    end

    // Captures that found the buffer full
    always_ff @(posedge itf) begin
        if (rst || flush) begin
            dropped <= '0;
        end else if (capture && full) begin
            // Stick at all ones
            if (dropped != '1) begin
                dropped <= dropped + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/trace_fifo.sv */
`default_nettype none

module trace_fifo (
    input  logic                           itf,
    input  logic                           rst,
    input  logic                           flush,
    input  logic                           push,
    input  trace_pkg::commit_rec_t         push_rec,
    input  logic                           pop,
    output trace_pkg::commit_rec_t         head,
    output logic                           not_empty,
    output logic                           full,
    output logic [trace_pkg::LEVEL_W-1:0]  level
);
    import trace_pkg::*;

    // Record storage
    commit_rec_t slots [TRACE_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic do_push;
    logic do_pop;

    // Wrap at the last slot, works for any depth
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(TRACE_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign not_empty = (level != '0);
    assign full      = (level == LEVEL_W'(TRACE_DEPTH));
    // Pop on empty is ignored
    assign do_pop    = pop && not_empty;
    // Full buffer takes a push only if a slot frees on the same edge
    assign do_push   = push && (!full || do_pop);

    // Head is read straight out of storage
    assign head = slots[rd_ptr];

    always_ff @(posedge itf) begin
        if (do_push) begin
            slots[wr_ptr] <= push_rec;
        end
    end

    always_ff @(posedge itf) begin
        if (rst || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            // Level unchanged on push with pop
            case ({do_push, do_pop})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;
            endcase
        end
    end

endmodule

`default_nettype wire

/* hdl/trace_top.sv */
`default_nettype none

module trace_top (
    input  logic                     itf,
    input  logic                     rst,
    input  trace_pkg::fetch_tap_t    fetch,
    input  trace_pkg::ex_tap_t       ex,
    input  trace_pkg::mem_tap_t      mem,
    input  trace_pkg::wb_tap_t       wb,
    input  trace_pkg::stall_t        stall,
    input  logic                     start,
    input  logic                     clear,
    input  logic                     pop,
    output trace_pkg::commit_rec_t   rec,
    output logic                     rec_valid,
    output trace_pkg::trace_status_t status
);
    import trace_pkg::*;

    logic               commit;
    commit_rec_t        shadow_rec;
    commit_rec_t        push_rec;
    trace_state_t       state;
    logic               capture;
    logic               flush;
    logic               full;
    logic               push;
    word_t              order;
    logic [DROP_W-1:0]  dropped;
    logic [LEVEL_W-1:0] level;

    shadow_pipe u_shadow (
        .itf    (itf),
        .fetch  (fetch),
        .ex     (ex),
        .mem    (mem),
        .wb     (wb),
        .stall  (stall),
        .commit (commit),
        .rec    (shadow_rec)
    );

    trace_ctrl u_ctrl (
        .itf     (itf),
        .rst     (rst),
        .start   (start),
        .clear   (clear),
        .commit  (commit),
        .halt    (shadow_rec.halt),
        .state   (state),
        .capture (capture),
        .flush   (flush)
    );

    retire_counter u_count (
        .itf     (itf),
        .rst     (rst),
        .flush   (flush),
        .capture (capture),
        .full    (full),
        .order   (order),
        .dropped (dropped)
    );

    // Stamp the record with its retire order
    always_comb begin
        push_rec       = shadow_rec;
        push_rec.order = order;
    end

    // Never wait on the reader, drop instead
    assign push = capture && !full;

    trace_fifo u_fifo (
        .itf       (itf),
        .rst       (rst),
        .flush     (flush),
        .push      (push),
        .push_rec  (push_rec),
        .pop       (pop),
        .head      (rec),
        .not_empty (rec_valid),
        .full      (full),
        .level     (level)
    );

    // Retired count is the running order
    assign status = '{state: state, level: level, dropped: dropped, retired: order};

endmodule

`default_nettype wire

/* test/trace_sva.sv */
`default_nettype none

module trace_sva (
    input logic                          itf,
    input logic                          rst,
    input logic                          flush,
    input logic                          push,
    input logic                          pop,
    input logic                          not_empty,
    input logic                          full,
    input logic [trace_pkg::LEVEL_W-1:0] level,
    input logic [trace_pkg::PTR_W-1:0]   rd_ptr,
    input logic [trace_pkg::PTR_W-1:0]   wr_ptr
);
    timeunit 1ns;
    timeprecision 1ps;
    import trace_pkg::*;

    // Count of failed assertions
    int unsigned fail_count = 0;

    // Fill level bounded by the storage
    level_bound: assert property (
        @(posedge itf) disable iff (rst) level <= LEVEL_W'(TRACE_DEPTH)
    ) else begin
        $error("buffer level above depth");
        fail_count++;
    end

    // Pop on an empty buffer leaves the read side alone
    empty_pop: assert property (
        @(posedge itf) disable iff (rst || flush)
        (!not_empty && pop) |=> (rd_ptr == $past(rd_ptr))
    ) else begin
        $error("read pointer moved on pop while empty");
        fail_count++;
    end

    // Full buffer without a pop keeps its write side
    full_hold: assert property (
        @(posedge itf) disable iff (rst || flush)
        (full && !pop) |=> (wr_ptr == $past(wr_ptr))
    ) else begin
        $error("write pointer moved while buffer full");
        fail_count++;
    end

endmodule

bind trace_fifo trace_sva sva0 (
    .itf       (itf),
    .rst       (rst),
    .flush     (flush),
    .push      (push),
    .pop       (pop),
    .not_empty (not_empty),
    .full      (full),
    .level     (level),
    .rd_ptr    (rd_ptr),
    .wr_ptr    (wr_ptr)
);

`default_nettype wire

/* test/trace_tb.sv */
`default_nettype none

module trace_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import trace_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int RST_CYCLES = 5;
    localparam int T1_CYCLES = 20;
    localparam int T2_CYCLES = 20;
    localparam int T3_CYCLES = 200;
    localparam int T4_CYCLES = 40;
    localparam int T5_CYCLES = 40;
    // Five drains of at most a full buffer each
    localparam int DRAIN_CYCLES = 20;
    localparam int TOTAL_CYCLES = RST_CYCLES + T1_CYCLES + T2_CYCLES + T3_CYCLES
                                + T4_CYCLES + T5_CYCLES + 5 * DRAIN_CYCLES;
    localparam logic [31:0] HALT_WORD = 32'h0000_0063;

    logic          itf = 1'b0;
    logic          rst;
    fetch_tap_t    fetch;
    ex_tap_t       ex;
    mem_tap_t      mem;
    wb_tap_t       wb;
    stall_t        stall;
    logic          start;
    logic          clear;
    logic          pop;
    commit_rec_t   rec;
    logic          rec_valid;
    trace_status_t status;

    // Stimulus knobs
    bit stall_en;
    bit redirect_en;
    bit halt_next;
    int valid_mode;
    int pop_mode;

    // Reference model state
    commit_rec_t   s_id;
    commit_rec_t   s_ex;
    commit_rec_t   s_mem;
    commit_rec_t   s_wb;
    commit_rec_t   exp_q[$];
    trace_state_t  m_state;
    word_t         m_order;
    logic [15:0]   m_dropped;
    logic          m_flush;

    trace_top dut0 (
        .itf       (itf),
        .rst       (rst),
        .fetch     (fetch),
        .ex        (ex),
        .mem       (mem),
        .wb        (wb),
        .stall     (stall),
        .start     (start),
        .clear     (clear),
        .pop       (pop),
        .rec       (rec),
        .rec_valid (rec_valid),
        .status    (status)
    );

    always #(CLK_PERIOD / 2) itf = ~itf;

    // Model of the trace unit, updated on the same edge as the DUT
    always @(posedge itf) begin : model
        commit_rec_t r;
        bit c;
        bit was_full;
        r = s_wb;
        r.order = m_order;
        r.rs1_addr = wb.rs1;
        r.rs2_addr = wb.rs2;
        r.rd_addr = wb.rd;
        r.rd_wdata = (wb.rd == 5'd0) ? 32'h0 : wb.rd_wdata;
        r.halt = (s_wb.insn == HALT_WORD);
        // Commit seen while capturing
        c = wb.valid && !stall.wb && (m_state == CAPTURE);
        was_full = (exp_q.size() == TRACE_DEPTH);
        if (rst || m_flush) begin
            exp_q.delete();
            m_order = '0;
            m_dropped = '0;
        end else begin
            if (pop && exp_q.size() != 0) begin
                void'(exp_q.pop_front());
            end
            if (c && !was_full) begin
                exp_q.push_back(r);
            end else if (c && m_dropped != 16'hffff) begin
                m_dropped++;
            end
            if (c) begin
                m_order++;
            end
        end
        if (rst || clear) begin
            m_state = IDLE;
        end else if (m_state == IDLE && start) begin
            m_state = CAPTURE;
        end else if (c && r.halt === 1'b1) begin
            m_state = HALTED;
        end
        // Buffer and counters clear one edge later
        m_flush = rst || clear;
        // Stages move back to front
        if (!stall.wb) begin
            s_wb = s_mem;
            s_wb.mem_addr = mem.addr;
            s_wb.mem_rdata = mem.rdata;
            s_wb.mem_wdata = mem.wdata;
            s_wb.mem_rmask = mem.read ? 4'hf : 4'h0;
            s_wb.mem_wmask = mem.write ? mem.byte_enable : 4'h0;
        end
        if (!stall.mem) begin
            s_mem = s_ex;
            if (ex.redirect) begin
                s_mem.pc_wdata = ex.redirect_pc;
            end
        end
        if (!stall.ex) begin
            s_ex = s_id;
            s_ex.rs1_rdata = ex.rs1_rdata;
            s_ex.rs2_rdata = ex.rs2_rdata;
        end
        if (!stall.id) begin
            s_id = '0;
            s_id.insn = fetch.insn;
            s_id.pc_rdata = fetch.pc;
            s_id.pc_wdata = fetch.pc_next;
        end
    end

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp);
            $display("tests failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic check_rec(input commit_rec_t got, input commit_rec_t exp);
        compare_field("rec.order", got.order, exp.order);
        compare_field("rec.insn", got.insn, exp.insn);
        compare_field("rec.pc_rdata", got.pc_rdata, exp.pc_rdata);
        compare_field("rec.pc_wdata", got.pc_wdata, exp.pc_wdata);
        compare_field("rec.rs1_addr", got.rs1_addr, exp.rs1_addr);
        compare_field("rec.rs2_addr", got.rs2_addr, exp.rs2_addr);
        compare_field("rec.rs1_rdata", got.rs1_rdata, exp.rs1_rdata);
        compare_field("rec.rs2_rdata", got.rs2_rdata, exp.rs2_rdata);
        compare_field("rec.rd_addr", got.rd_addr, exp.rd_addr);
        compare_field("rec.rd_wdata", got.rd_wdata, exp.rd_wdata);
        compare_field("rec.mem_addr", got.mem_addr, exp.mem_addr);
        compare_field("rec.mem_rmask", got.mem_rmask, exp.mem_rmask);
        compare_field("rec.mem_wmask", got.mem_wmask, exp.mem_wmask);
        compare_field("rec.mem_rdata", got.mem_rdata, exp.mem_rdata);
        compare_field("rec.mem_wdata", got.mem_wdata, exp.mem_wdata);
        compare_field("rec.halt", got.halt, exp.halt);
    endtask

    task automatic check_status(input trace_status_t got, input trace_status_t exp);
        compare_field("status.state", got.state, exp.state);
        compare_field("status.level", got.level, exp.level);
        compare_field("status.dropped", got.dropped, exp.dropped);
        compare_field("status.retired", got.retired, exp.retired);
    endtask

    task automatic check_outputs();
        trace_status_t exp_status;
        exp_status.state = m_state;
        exp_status.level = LEVEL_W'(exp_q.size());
        exp_status.dropped = m_dropped;
        exp_status.retired = m_order;
        compare_field("rec_valid", rec_valid, exp_q.size() != 0);
        if (exp_q.size() != 0) begin
            check_rec(rec, exp_q[0]);
        end
        // x0 destination never reports data
        if (rec_valid && rec.rd_addr == 5'd0) begin
            compare_field("rec.rd_wdata", rec.rd_wdata, 32'h0);
        end
        check_status(status, exp_status);
    endtask

    task automatic drive_inputs();
        fetch.insn = $urandom();
        // Keep the halt idiom out of random code
        if (fetch.insn == HALT_WORD) begin
            fetch.insn = 32'h0000_0013;
        end
        if (halt_next) begin
            fetch.insn = HALT_WORD;
            halt_next = 1'b0;
        end
        fetch.pc = $urandom() & ~32'h3;
        fetch.pc_next = $urandom();
        ex.rs1_rdata = $urandom();
        ex.rs2_rdata = $urandom();
        ex.redirect = redirect_en && ($urandom_range(1) == 1);
        ex.redirect_pc = $urandom();
        mem.addr = $urandom();
        mem.rdata = $urandom();
        mem.wdata = $urandom();
        mem.read = $urandom_range(1);
        mem.write = $urandom_range(1);
        mem.byte_enable = $urandom_range(15);
        wb.rs1 = $urandom_range(31);
        wb.rs2 = $urandom_range(31);
        // Roughly a quarter of writes go to x0
        wb.rd = ($urandom_range(3) == 0) ? 5'd0 : 5'($urandom_range(31));
        wb.rd_wdata = $urandom();
        case (valid_mode)
            0: wb.valid = 1'b0;
            1: wb.valid = ($urandom_range(3) != 0);
            default: wb.valid = 1'b1;
        endcase
        stall.id = stall_en && ($urandom_range(3) == 0);
        stall.ex = stall_en && ($urandom_range(3) == 0);
        stall.mem = stall_en && ($urandom_range(3) == 0);
        stall.wb = stall_en && ($urandom_range(3) == 0);
        pop = (pop_mode == 1) || (pop_mode == 2 && $urandom_range(3) != 0);
    endtask

    // Check after the edge, then drive the next cycle
    task automatic step();
        @(posedge itf);
        #2;
        check_outputs();
        drive_inputs();
    endtask

    task automatic run_cycles(input int n);
        repeat (n) step();
    endtask

    // Pop everything, orders must run on from first
    task automatic drain_checked(input word_t first, output int n, output logic last_halt);
        word_t next;
        next = first;
        n = 0;
        last_halt = 1'b0;
        valid_mode = 0;
        pop_mode = 0;
        step();
        pop = 1'b1;
        pop_mode = 1;
        while (rec_valid) begin
            compare_field("rec.order", rec.order, next);
            last_halt = rec.halt;
            next = next + 1;
            n++;
            step();
        end
        pop_mode = 0;
        pop = 1'b0;
    endtask

    task automatic test_reset_idle();
        step();
        compare_field("status.state", status.state, IDLE);
        compare_field("status.level", status.level, 0);
        compare_field("status.retired", status.retired, 0);
        compare_field("status.dropped", status.dropped, 0);
        compare_field("rec_valid", rec_valid, 0);
        // Commits before start are not traced
        valid_mode = 1;
        run_cycles(T1_CYCLES);
        compare_field("status.level", status.level, 0);
        compare_field("status.retired", status.retired, 0);
    endtask

    task automatic test_stream();
        int n;
        logic h;
        valid_mode = 2;
        start = 1'b1;
        step();
        start = 1'b0;
        run_cycles(T2_CYCLES / 2);
        drain_checked(0, n, h);
        compare_field("drained count", n, m_order);
    endtask

    task automatic test_stalls_redirect();
        int n;
        logic h;
        word_t first;
        stall_en = 1'b1;
        redirect_en = 1'b1;
        valid_mode = 1;
        pop_mode = 2;
        run_cycles(T3_CYCLES);
        stall_en = 1'b0;
        redirect_en = 1'b0;
        // Quiet cycle so the head holds still
        pop_mode = 0;
        valid_mode = 0;
        step();
        // Order of the oldest record still buffered
        first = (exp_q.size() != 0) ? exp_q[0].order : m_order;
        drain_checked(first, n, h);
    endtask

    task automatic test_back_pressure();
        word_t base;
        logic [15:0] dropped0;
        int n;
        logic h;
        base = m_order;
        dropped0 = m_dropped;
        valid_mode = 2;
        while (status.level != LEVEL_W'(TRACE_DEPTH)) begin
            step();
        end
        run_cycles(6);
        compare_field("status.level", status.level, TRACE_DEPTH);
        // Every commit past the first sixteen is dropped
        compare_field("status.dropped", status.dropped,
                      dropped0 + m_order - base - TRACE_DEPTH);
        drain_checked(base, n, h);
        compare_field("drained count", n, TRACE_DEPTH);
    endtask

    task automatic test_halt();
        word_t r0;
        int n;
        logic h;
        r0 = m_order;
        valid_mode = 2;
        run_cycles(3);
        halt_next = 1'b1;
        while (status.state != HALTED) begin
            step();
        end
        // Commits after the halt are ignored
        run_cycles(10);
        compare_field("status.state", status.state, HALTED);
        drain_checked(r0, n, h);
        compare_field("last record halt", h, 1);
        compare_field("drained count", n, m_order - r0);
        clear = 1'b1;
        step();
        clear = 1'b0;
        step();
        compare_field("status.state", status.state, IDLE);
        compare_field("status.retired", status.retired, 0);
        compare_field("status.dropped", status.dropped, 0);
        compare_field("status.level", status.level, 0);
        valid_mode = 1;
        start = 1'b1;
        step();
        start = 1'b0;
        run_cycles(T5_CYCLES / 2);
        drain_checked(0, n, h);
        compare_field("drained count", n, m_order);
    endtask

    initial begin
        void'($urandom(9));
        rst = 1'b1;
        start = 1'b0;
        clear = 1'b0;
        pop = 1'b0;
        fetch = '0;
        ex = '0;
        mem = '0;
        wb = '0;
        stall = '0;
        stall_en = 1'b0;
        redirect_en = 1'b0;
        halt_next = 1'b0;
        valid_mode = 0;
        pop_mode = 0;
        repeat (RST_CYCLES) @(posedge itf);
        #2;
        rst = 1'b0;
        test_reset_idle();
        test_stream();
        test_stalls_redirect();
        test_back_pressure();
        test_halt();
        $display("all tests passed");
        $finish;
    end

    // First failed buffer assertion ends the run
    initial begin
        wait (dut0.u_fifo.sva0.fail_count != 0);
        $display("Assertion failure in trace buffer checker");
        $display("tests failed");
        $fatal(1, "assertion failure");
    end

    // Twice the summed length of all tests
    initial begin
        #(2 * TOTAL_CYCLES * CLK_PERIOD);
        $display("Timeout: run did not finish within %0d ns", 2 * TOTAL_CYCLES * CLK_PERIOD);
        $display("tests failed");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

/* project.f */
hdl/trace_pkg.sv
hdl/shadow_pipe.sv
hdl/trace_ctrl.sv
hdl/retire_counter.sv
hdl/trace_fifo.sv
hdl/trace_top.sv
test/trace_sva.sv
test/trace_tb.sv
